//--- logic/fmap_settings.svh
`ifndef FMAP_SETTINGS_SVH
`define FMAP_SETTINGS_SVH

// feature map buffer sizing

// bits of one float16 value
`define FMAP_DATA_WIDTH 16

// lanes per buffer word
// one lane per MAC in a group
`define FMAP_PARA_Y 2

// number of words in the buffer
// must stay a power of two so base plus offset wraps for free
`define FMAP_DEPTH 16

// word address width
// log2 of FMAP_DEPTH
`define FMAP_ADDR_WIDTH 4

`endif

//--- logic/fmap_pkg.sv
`include "fmap_settings.svh"

package fmap_pkg;

	// one half precision value
	typedef logic [`FMAP_DATA_WIDTH-1:0] fp16_t;

	// one buffer word
	// lane 0 sits in the low bits
	typedef fp16_t [`FMAP_PARA_Y-1:0] lane_vec_t;

	// replace the word or add onto it
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_ACCUM = 1'b1
	} psum_op_e;

	// partial sum beat from the MAC group
	typedef struct packed {
		psum_op_e op;
		logic [`FMAP_ADDR_WIDTH-1:0] addr;
		lane_vec_t data;
	} psum_beat_t;

	// read command
	// word address is base plus offset
	typedef struct packed {
		logic [`FMAP_ADDR_WIDTH-1:0] base;
		logic [`FMAP_ADDR_WIDTH-1:0] offset;
	} rd_cmd_t;

	typedef enum logic [1:0] {
		W_IDLE  = 2'd0,
		W_ISSUE = 2'd1,
		W_ACK   = 2'd2
	} writer_state_e;

	typedef enum logic [1:0] {
		R_IDLE = 2'd0,
		R_WAIT = 2'd1,
		R_ACK  = 2'd2
	} reader_state_e;

endpackage

//--- logic/fp16_add.sv
`timescale 1ns/1ps

module fp16_add (
	input  fmap_pkg::fp16_t a,
	input  fmap_pkg::fp16_t b,
	output fmap_pkg::fp16_t sum
);
	// operands with subnormals flushed to signed zero
	fmap_pkg::fp16_t a_flush;
	fmap_pkg::fp16_t b_flush;
	logic a_inf;
	logic b_inf;
	// larger and smaller magnitude operand
	fmap_pkg::fp16_t hi_op;
	fmap_pkg::fp16_t lo_op;
	logic [4:0] exp_diff;
	logic [10:0] hi_man;
	logic [10:0] lo_man;
	logic [10:0] lo_aligned;
	// mantissa sum with carry bit
	logic [11:0] raw;
	logic [3:0] lead_zeros;
	logic signed [6:0] exp_res;
	logic [10:0] norm_man;

	assign a_flush = (a[14:10] == 5'd0) ? {a[15], 15'd0} : a;
	assign b_flush = (b[14:10] == 5'd0) ? {b[15], 15'd0} : b;
	assign a_inf = (a[14:10] == 5'h1f);
	assign b_inf = (b[14:10] == 5'h1f);

	// magnitude order keeps the difference non negative
	assign hi_op = (b_flush[14:0] > a_flush[14:0]) ? b_flush : a_flush;
	assign lo_op = (b_flush[14:0] > a_flush[14:0]) ? a_flush : b_flush;
	assign exp_diff = hi_op[14:10] - lo_op[14:10];

	// hidden one only for a nonzero exponent
	assign hi_man = {|hi_op[14:10], hi_op[9:0]};
	assign lo_man = {|lo_op[14:10], lo_op[9:0]};
	// shifted out bits are lost, so the result truncates
	assign lo_aligned = lo_man >> exp_diff;

	// same signs add, different signs subtract
	assign raw = (hi_op[15] == lo_op[15]) ?
		({1'b0, hi_man} + {1'b0, lo_aligned}) :
		({1'b0, hi_man} - {1'b0, lo_aligned});

	// leading zero search over the low 11 bits
	always_comb begin
		lead_zeros = 4'd11;
		for (int i = 0; i <= 10; i++) begin
			if (raw[i]) begin
				lead_zeros = 4'(10 - i);
			end
		end
	end

	always_comb begin
		// cancellation case shifts left
		exp_res = {2'b00, hi_op[14:10]} - {3'b000, lead_zeros};
		norm_man = raw[10:0] << lead_zeros;
		// carry out shifts right by one
		if (raw[11]) begin
			exp_res = {2'b00, hi_op[14:10]} + 7'sd1;
			norm_man = raw[11:1];
		end
		if (a_inf || b_inf) begin
			// infinity passes through
			sum = a_inf ? a : b;
		end else if (raw == 12'd0) begin
			sum = '0;
		end else if (exp_res >= 7'sd31) begin
			// overflow saturates to infinity
			sum = {hi_op[15], 5'h1f, 10'd0};
		end else if (exp_res <= 7'sd0) begin
			// underflow goes to zero
			sum = '0;
		end else begin
			sum = {hi_op[15], exp_res[4:0], norm_man[9:0]};
		end
	end

endmodule

//--- logic/psum_writer.sv
`timescale 1ns/1ps
`include "fmap_settings.svh"

module psum_writer (
	input  logic clk,
	input  logic reset,
	// four phase write channel
	input  logic wr_req,
	input  fmap_pkg::psum_beat_t wr_beat,
	output logic wr_ack,
	// buffer side
	input  logic write_ready,
	output logic mem_wr_en,
	output fmap_pkg::psum_op_e mem_wr_op,
	output logic [`FMAP_ADDR_WIDTH-1:0] mem_wr_addr,
	output fmap_pkg::lane_vec_t mem_wr_data
);
	fmap_pkg::writer_state_e state;
	// beat held for the whole transfer
	fmap_pkg::psum_beat_t beat_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fmap_pkg::W_IDLE;
			wr_ack <= 1'b0;
			mem_wr_en <= 1'b0;
		end else begin
			// strobe lasts one cycle
			mem_wr_en <= 1'b0;
			case (state)
				fmap_pkg::W_IDLE: begin
					// ack is low here so a new request may start
					if (wr_req) begin
						state <= fmap_pkg::W_ISSUE;
					end
				end
				fmap_pkg::W_ISSUE: begin
					// back pressure while an accumulation is in flight
					if (write_ready) begin
						mem_wr_en <= 1'b1;
						state <= fmap_pkg::W_ACK;
					end
				end
				fmap_pkg::W_ACK: begin
					if (!wr_ack) begin
						// ack in the cycle after the strobe
						wr_ack <= 1'b1;
					end else if (!wr_req) begin
						// source released the request
						wr_ack <= 1'b0;
						state <= fmap_pkg::W_IDLE;
					end
				end
				default: begin
					state <= fmap_pkg::W_IDLE;
				end
			endcase
		end
	end

	// latch the beat when the request is accepted
	always_ff @(posedge clk) begin
		if (state == fmap_pkg::W_IDLE && wr_req) begin
			beat_q <= wr_beat;
		end
	end

	assign mem_wr_op = beat_q.op;
	assign mem_wr_addr = beat_q.addr;
	assign mem_wr_data = beat_q.data;

endmodule

//--- logic/fmap_ram_fp16.sv
`timescale 1ns/1ps
`include "fmap_settings.svh"

module fmap_ram_fp16 (
	input  logic clk,
	input  logic reset,
	// write port from the writer
	input  logic mem_wr_en,
	input  fmap_pkg::psum_op_e mem_wr_op,
	input  logic [`FMAP_ADDR_WIDTH-1:0] mem_wr_addr,
	input  fmap_pkg::lane_vec_t mem_wr_data,
	output logic write_ready,
	// read port from the reader
	input  logic mem_rd_en,
	input  logic [`FMAP_ADDR_WIDTH-1:0] mem_rd_addr,
	output fmap_pkg::lane_vec_t mem_rd_data
);
	fmap_pkg::lane_vec_t mem [`FMAP_DEPTH];

	logic plain_strobe;
	logic accum_strobe;
	// write-back due at the next edge
	logic acc_valid;
	// one cycle after the write-back
	logic wb_tail;
	logic [`FMAP_ADDR_WIDTH-1:0] acc_addr;
	fmap_pkg::lane_vec_t acc_old;
	fmap_pkg::lane_vec_t acc_new;
	fmap_pkg::lane_vec_t acc_sum;

	assign plain_strobe = mem_wr_en && (mem_wr_op == fmap_pkg::OP_WRITE);
	assign accum_strobe = mem_wr_en && (mem_wr_op == fmap_pkg::OP_ACCUM);

	// one adder per lane
	generate
		for (genvar lane = 0; lane < `FMAP_PARA_Y; lane++) begin : g_lane
			fp16_add u_add (
				.a(acc_old[lane]),
				.b(acc_new[lane]),
				.sum(acc_sum[lane])
			);
		end
	endgenerate

	// busy flag and write-back pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_valid <= 1'b0;
			wb_tail <= 1'b0;
			write_ready <= 1'b1;
		end else begin
			acc_valid <= accum_strobe;
			wb_tail <= acc_valid;
			// low for the operand cycle and the write-back cycle
			if (accum_strobe) begin
				write_ready <= 1'b0;
			end else if (wb_tail) begin
				write_ready <= 1'b1;
			end
		end
	end

	// old word and new beat registered at the strobe
	always_ff @(posedge clk) begin
		if (accum_strobe) begin
			acc_old <= mem[mem_wr_addr];
			acc_new <= mem_wr_data;
			acc_addr <= mem_wr_addr;
		end
	end

	// storage
	// write-back and plain write never meet since the writer waits on write_ready
	always_ff @(posedge clk) begin
		if (acc_valid) begin
			mem[acc_addr] <= acc_sum;
		end else if (plain_strobe) begin
			mem[mem_wr_addr] <= mem_wr_data;
		end
	end

	// registered read, data one cycle after the strobe
	always_ff @(posedge clk) begin
		if (mem_rd_en) begin
			mem_rd_data <= mem[mem_rd_addr];
		end
	end

endmodule

//--- logic/fmap_reader.sv
`timescale 1ns/1ps
`include "fmap_settings.svh"

module fmap_reader (
	input  logic clk,
	input  logic reset,
	// four phase read channel
	input  logic rd_req,
	input  fmap_pkg::rd_cmd_t rd_cmd,
	output logic rd_ack,
	output fmap_pkg::lane_vec_t rd_data,
	// buffer side
	output logic mem_rd_en,
	output logic [`FMAP_ADDR_WIDTH-1:0] mem_rd_addr,
	input  fmap_pkg::lane_vec_t mem_rd_data
);
	fmap_pkg::reader_state_e state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fmap_pkg::R_IDLE;
			rd_ack <= 1'b0;
			mem_rd_en <= 1'b0;
		end else begin
			case (state)
				fmap_pkg::R_IDLE: begin
					// strobe in the cycle after the request is seen
					if (rd_req) begin
						mem_rd_en <= 1'b1;
						state <= fmap_pkg::R_WAIT;
					end
				end
				fmap_pkg::R_WAIT: begin
					// first cycle drops the strobe
					// second cycle has the buffer data
					if (mem_rd_en) begin
						mem_rd_en <= 1'b0;
					end else begin
						state <= fmap_pkg::R_ACK;
					end
				end
				fmap_pkg::R_ACK: begin
					if (!rd_ack) begin
						rd_ack <= 1'b1;
					end else if (!rd_req) begin
						rd_ack <= 1'b0;
						state <= fmap_pkg::R_IDLE;
					end
				end
				default: begin
					state <= fmap_pkg::R_IDLE;
					mem_rd_en <= 1'b0;
				end
			endcase
		end
	end

	// address and returned word
	always_ff @(posedge clk) begin
		if (state == fmap_pkg::R_IDLE && rd_req) begin
			// carry drops out, wraps modulo depth
			mem_rd_addr <= rd_cmd.base + rd_cmd.offset;
		end
		// held until the next command
		if (state == fmap_pkg::R_WAIT && !mem_rd_en) begin
			rd_data <= mem_rd_data;
		end
	end

endmodule

//--- logic/fmap_top.sv
`timescale 1ns/1ps
`include "fmap_settings.svh"

module fmap_top (
	input  logic clk,
	input  logic reset,
	// partial sum channel
	input  logic wr_req,
	input  fmap_pkg::psum_beat_t wr_beat,
	output logic wr_ack,
	// read channel
	input  logic rd_req,
	input  fmap_pkg::rd_cmd_t rd_cmd,
	output logic rd_ack,
	output fmap_pkg::lane_vec_t rd_data
);
	// writer to buffer
	logic mem_wr_en;
	fmap_pkg::psum_op_e mem_wr_op;
	logic [`FMAP_ADDR_WIDTH-1:0] mem_wr_addr;
	fmap_pkg::lane_vec_t mem_wr_data;
	logic write_ready;
	// reader to buffer
	logic mem_rd_en;
	logic [`FMAP_ADDR_WIDTH-1:0] mem_rd_addr;
	fmap_pkg::lane_vec_t mem_rd_data;

	psum_writer psum_writer_i (
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.wr_beat(wr_beat),
		.wr_ack(wr_ack),
		.write_ready(write_ready),
		.mem_wr_en(mem_wr_en),
		.mem_wr_op(mem_wr_op),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data)
	);

	fmap_ram_fp16 fmap_ram_i (
		.clk(clk),
		.reset(reset),
		.mem_wr_en(mem_wr_en),
		.mem_wr_op(mem_wr_op),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data),
		.write_ready(write_ready),
		.mem_rd_en(mem_rd_en),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_data(mem_rd_data)
	);

	fmap_reader fmap_reader_i (
		.clk(clk),
		.reset(reset),
		.rd_req(rd_req),
		.rd_cmd(rd_cmd),
		.rd_ack(rd_ack),
		.rd_data(rd_data),
		.mem_rd_en(mem_rd_en),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_data(mem_rd_data)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	// full period in ns
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// toggle every half period
	always begin
		#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

//--- tests/fmap_assertions.sv
`timescale 1ns/1ps

module fmap_assertions (
	input logic clk,
	input logic reset,
	input logic wr_req,
	input fmap_pkg::psum_beat_t wr_beat,
	input logic wr_ack,
	input logic rd_req,
	input fmap_pkg::rd_cmd_t rd_cmd,
	input logic rd_ack,
	input logic mem_wr_en,
	input fmap_pkg::psum_op_e mem_wr_op,
	input logic write_ready
);
	// assertion failures seen so far
	int fail_count = 0;

	// ack only rises on a live request
	// the source may drop req in the same cycle it sees the ack
	assert property (@(posedge clk) disable iff (reset) $rose(wr_ack) |-> $past(wr_req))
	else begin
		$error("wr_ack rose without wr_req");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset) $rose(rd_ack) |-> $past(rd_req))
	else begin
		$error("rd_ack rose without rd_req");
		fail_count++;
	end

	// payload held until the ack comes back
	assert property (@(posedge clk) disable iff (reset)
		(wr_req && !wr_ack) |=> (!wr_req || $stable(wr_beat)))
	else begin
		$error("wr_beat changed during the request phase");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		(rd_req && !rd_ack) |=> (!rd_req || $stable(rd_cmd)))
	else begin
		$error("rd_cmd changed during the request phase");
		fail_count++;
	end

	// writer honours back pressure
	assert property (@(posedge clk) disable iff (reset) mem_wr_en |-> write_ready)
	else begin
		$error("write strobe while the buffer was busy");
		fail_count++;
	end

	// busy for the operand cycle and the write-back cycle only
	assert property (@(posedge clk) disable iff (reset)
		(mem_wr_en && mem_wr_op == fmap_pkg::OP_ACCUM)
		|=> !write_ready ##1 !write_ready ##1 write_ready)
	else begin
		$error("write_ready not low for exactly two cycles after an accumulate");
		fail_count++;
	end

endmodule

bind fmap_top fmap_assertions fmap_assertions_i (
	.clk(clk),
	.reset(reset),
	.wr_req(wr_req),
	.wr_beat(wr_beat),
	.wr_ack(wr_ack),
	.rd_req(rd_req),
	.rd_cmd(rd_cmd),
	.rd_ack(rd_ack),
	.mem_wr_en(mem_wr_en),
	.mem_wr_op(mem_wr_op),
	.write_ready(write_ready)
);

//--- tests/fmap_tb.sv
`timescale 1ns/1ps
`include "fmap_settings.svh"

module fmap_tb;
	localparam int NUM_ROWS = 28;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 8;
	// 40 cycles per row plus reset
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;
	// request seen to ack
	localparam int READ_LATENCY = 3;
	// extra cycles rd_req stays high on a latency row
	localparam int HOLD_CYCLES = 3;

	typedef enum logic [1:0] {K_WRITE, K_ACCUM, K_READ, K_LATENCY} row_kind_e;

	// addr doubles as the read base
	typedef struct packed {
		logic [2:0] test_id;
		row_kind_e kind;
		logic [`FMAP_ADDR_WIDTH-1:0] addr;
		logic [`FMAP_ADDR_WIDTH-1:0] offset;
		fmap_pkg::lane_vec_t data;
		fmap_pkg::lane_vec_t exp_word;
	} row_t;

	logic clk;
	logic reset;
	logic wr_req;
	fmap_pkg::psum_beat_t wr_beat;
	logic wr_ack;
	logic rd_req;
	fmap_pkg::rd_cmd_t rd_cmd;
	logic rd_ack;
	fmap_pkg::lane_vec_t rd_data;

	row_t rows [NUM_ROWS];
	string test_names [NUM_TESTS];
	int test_checks [NUM_TESTS];
	int test_errors [NUM_TESTS];
	int cycle_count = 0;

	tb_clock clock_i (.clk(clk));

	fmap_top fmap_top_i (
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.wr_beat(wr_beat),
		.wr_ack(wr_ack),
		.rd_req(rd_req),
		.rd_cmd(rd_cmd),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

	function automatic row_t make_row(input int test_id, input row_kind_e kind, input int addr,
		input int offset, input logic [31:0] data, input logic [31:0] exp_word);
		row_t r;
		r.test_id = 3'(test_id);
		r.kind = kind;
		r.addr = `FMAP_ADDR_WIDTH'(addr);
		r.offset = `FMAP_ADDR_WIDTH'(offset);
		r.data = data;
		r.exp_word = exp_word;
		return r;
	endfunction

	// words are {lane 1, lane 0}
	// 3c00 1.0, 4000 2.0, 4200 3.0, 3800 0.5
	task automatic load_rows();
		test_names = '{"plain writes", "accumulation", "back-to-back", "adder edges",
			"address wrap", "read latency"};
		rows[0] = make_row(0, K_WRITE, 0, 0, 32'h4000_3c00, 32'h0);
		rows[1] = make_row(0, K_READ, 0, 0, 32'h0, 32'h4000_3c00);
		rows[2] = make_row(0, K_WRITE, 5, 0, 32'hc200_3800, 32'h0);
		rows[3] = make_row(0, K_READ, 5, 0, 32'h0, 32'hc200_3800);
		// 3+1+1 and 2+2+1 both give 5.0
		rows[4] = make_row(1, K_WRITE, 2, 0, 32'h4000_4200, 32'h0);
		rows[5] = make_row(1, K_ACCUM, 2, 0, 32'h4000_3c00, 32'h0);
		rows[6] = make_row(1, K_ACCUM, 2, 0, 32'h3c00_3c00, 32'h0);
		rows[7] = make_row(1, K_READ, 2, 0, 32'h0, 32'h4500_4500);
		// no idle cycles between beats
		// ends at 4.5 and 2.5
		rows[8] = make_row(2, K_WRITE, 7, 0, 32'h3c00_3800, 32'h0);
		rows[9] = make_row(2, K_ACCUM, 7, 0, 32'h3800_3800, 32'h0);
		rows[10] = make_row(2, K_ACCUM, 7, 0, 32'h3c00_3800, 32'h0);
		rows[11] = make_row(2, K_ACCUM, 7, 0, 32'h4000_3c00, 32'h0);
		rows[12] = make_row(2, K_READ, 7, 0, 32'h0, 32'h4480_4100);
		// opposite values cancel
		rows[13] = make_row(3, K_WRITE, 3, 0, 32'hc000_4000, 32'h0);
		rows[14] = make_row(3, K_ACCUM, 3, 0, 32'h4000_c000, 32'h0);
		rows[15] = make_row(3, K_READ, 3, 0, 32'h0, 32'h0000_0000);
		// subnormals flush to zero
		rows[16] = make_row(3, K_WRITE, 4, 0, 32'h3c00_4200, 32'h0);
		rows[17] = make_row(3, K_ACCUM, 4, 0, 32'h0200_8001, 32'h0);
		rows[18] = make_row(3, K_READ, 4, 0, 32'h0, 32'h3c00_4200);
		// past the largest finite value
		rows[19] = make_row(3, K_WRITE, 6, 0, 32'h7bff_7bff, 32'h0);
		rows[20] = make_row(3, K_ACCUM, 6, 0, 32'h7bff_7800, 32'h0);
		rows[21] = make_row(3, K_READ, 6, 0, 32'h0, 32'h7c00_7c00);
		// 12+5 wraps to 1, 15+15 wraps to 14
		rows[22] = make_row(4, K_WRITE, 1, 0, 32'h4200_3800, 32'h0);
		rows[23] = make_row(4, K_READ, 12, 5, 32'h0, 32'h4200_3800);
		rows[24] = make_row(4, K_WRITE, 14, 0, 32'h3800_4000, 32'h0);
		rows[25] = make_row(4, K_READ, 15, 15, 32'h0, 32'h3800_4000);
		rows[26] = make_row(5, K_WRITE, 9, 0, 32'h4400_c400, 32'h0);
		rows[27] = make_row(5, K_LATENCY, 8, 1, 32'h0, 32'h4400_c400);
	endtask

	// four phase write entered and left on a falling edge
	task automatic send_beat(input fmap_pkg::psum_op_e op,
		input logic [`FMAP_ADDR_WIDTH-1:0] addr, input fmap_pkg::lane_vec_t data);
		wr_beat.op = op;
		wr_beat.addr = addr;
		wr_beat.data = data;
		wr_req = 1'b1;
		do @(negedge clk); while (!wr_ack);
		wr_req = 1'b0;
		do @(negedge clk); while (wr_ack);
	endtask

	// four phase read held hold_cycles past the ack
	task automatic read_word(input logic [`FMAP_ADDR_WIDTH-1:0] base,
		input logic [`FMAP_ADDR_WIDTH-1:0] offset, input int hold_cycles,
		output fmap_pkg::lane_vec_t word, output int latency, output logic held);
		int waited;
		rd_cmd.base = base;
		rd_cmd.offset = offset;
		rd_req = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!rd_ack);
		// first edge is the one that sees the request
		latency = waited - 1;
		word = rd_data;
		held = 1'b1;
		repeat (hold_cycles) begin
			@(negedge clk);
			if (rd_data !== word || !rd_ack) begin
				held = 1'b0;
			end
		end
		rd_req = 1'b0;
		do @(negedge clk); while (rd_ack);
	endtask

	task automatic check_value(input int test_idx, input string name,
		input logic [31:0] exp_val, input logic [31:0] got);
		test_checks[test_idx]++;
		assert (got === exp_val) else begin
			$display("Fail time=%0t signal=%s expected=%h got=%h", $time, name, exp_val, got);
			test_errors[test_idx]++;
		end
	endtask

	// hang guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: a handshake did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		row_t r;
		fmap_pkg::lane_vec_t word;
		int latency;
		logic held;
		logic last;
		int checks;
		int errors;
		int assert_fails;
		wr_req = 1'b0;
		wr_beat = '0;
		rd_req = 1'b0;
		rd_cmd = '0;
		reset = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_checks[t] = 0;
			test_errors[t] = 0;
		end
		load_rows();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			r = rows[i];
			case (r.kind)
				K_WRITE: send_beat(fmap_pkg::OP_WRITE, r.addr, r.data);
				K_ACCUM: send_beat(fmap_pkg::OP_ACCUM, r.addr, r.data);
				default: begin
					read_word(r.addr, r.offset, (r.kind == K_LATENCY) ? HOLD_CYCLES : 0,
						word, latency, held);
					check_value(r.test_id, "rd_data", r.exp_word, word);
					check_value(r.test_id, "rd_ack latency", READ_LATENCY, latency);
					// only a latency row keeps rd_req high past the ack
					if (r.kind == K_LATENCY) begin
						test_checks[r.test_id]++;
						assert (held) else begin
							$display("rd_data changed or rd_ack fell while rd_req was still high");
							test_errors[r.test_id]++;
						end
					end
				end
			endcase
			// report a test after its last row
			last = (i == NUM_ROWS - 1) ? 1'b1 : (rows[i + 1].test_id != r.test_id);
			if (last) begin
				$display("test %0d %s: checks=%0d errors=%0d", r.test_id + 1,
					test_names[r.test_id], test_checks[r.test_id], test_errors[r.test_id]);
			end
		end
		checks = 0;
		errors = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			checks += test_checks[t];
			errors += test_errors[t];
		end
		assert_fails = fmap_top_i.fmap_assertions_i.fail_count;
		$display("checks=%0d errors=%0d assertion failures=%0d", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+logic
logic/fmap_pkg.sv
logic/fp16_add.sv
logic/psum_writer.sv
logic/fmap_ram_fp16.sv
logic/fmap_reader.sv
logic/fmap_top.sv
tests/tb_clock.sv
tests/fmap_assertions.sv
tests/fmap_tb.sv
